/* verilog.f */
+incdir+.
softmc_instr_pkg.sv
dfi_pkg.sv
instr_if.sv
instr_queue.sv
iseq_sequencer.sv
rdback_fifo.sv
softmc_top.sv
tb_clk_gen.sv
tb_softmc.sv

/* Bender.yml */
package:
  name: softmc

sources:
  - include_dirs:
      - .
    files:
      - softmc_instr_pkg.sv
      - dfi_pkg.sv
      - instr_if.sv
      - instr_queue.sv
      - iseq_sequencer.sv
      - rdback_fifo.sv
      - softmc_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clk_gen.sv
      - tb_softmc.sv

/* tb_softmc.sv */
`timescale 1ns/1ps
`default_nettype none

`include "softmc_defs.svh"

module tb_softmc;

   localparam int MODE_PLAIN = 0;
   localparam int MODE_HOLD = 1;      // END held back for an idle check
   localparam int MODE_READS = 2;
   localparam int MODE_OVERLAP = 3;   // next sequence is pushed while this one runs
   localparam int MODE_FILL = 4;
   localparam int N_READS = 10;
   localparam logic [3:0] CTL_MRS = 4'b0000;   // cs_n ras_n cas_n we_n
   localparam logic [3:0] CTL_REF = 4'b0001;
   localparam logic [3:0] CTL_PRE = 4'b0010;
   localparam logic [3:0] CTL_ACT = 4'b0011;
   localparam logic [3:0] CTL_WR = 4'b0100;
   localparam logic [3:0] CTL_RD = 4'b0101;

   typedef struct packed {
      logic [7:0]  gap;   // 0 when not fixed
      logic [3:0]  ctl;
      logic [2:0]  bank;
      logic [15:0] addr;
      logic        wr_en;
      logic        rd_en;
      logic [63:0] wrdata;
   } exp_cmd_t;

   logic clk;
   logic i_rst_n;
   logic i_app_en;
   logic o_app_ack;
   logic [31:0] i_app_instr;
   logic i_rdback_rden;
   logic [63:0] o_rdback_data;
   logic o_rdback_empty;
   logic o_processing_iseq;
   logic o_iq_full;
   logic [15:0] o_dfi_address;
   logic [2:0] o_dfi_bank;
   logic o_dfi_cs_n, o_dfi_ras_n, o_dfi_cas_n, o_dfi_we_n;
   logic o_dfi_wrdata_en;
   logic [63:0] o_dfi_wrdata;
   logic o_dfi_rddata_en;
   logic [63:0] i_dfi_rddata;
   logic i_dfi_rddata_valid;

   logic [31:0] instr_tab [64];
   exp_cmd_t    exp_tab [48];
   int seq_first [8];
   int seq_last [8];
   int seq_mode [8];
   int seq_cmd_first [8];
   int seq_cmd_end [8];
   int n_instr = 0;
   int n_cmd = 0;
   int n_seq = 0;
   int pend_gap;
   int wait_sum = 0;
   logic [15:0] cur_pattern;

   int err_cnt = 0;
   int cmd_idx = 0;
   int cycle_cnt = 0;
   int last_cmd_cycle = 0;
   int limit_cycles = 0;
   int rd_returned = 0;
   logic [63:0] exp_rdq [$];
   logic [31:0] rng = 32'd83;
   logic [2:0] rd_pipe_v = '0;
   logic [15:0] rd_pipe_a [3];

   tb_clk_gen #(.PERIOD_NS(100.0)) u_clk_gen (.o_clk(clk));

   softmc_top DUT (
      .i_clk              (clk),
      .i_rst_n            (i_rst_n),
      .i_app_en           (i_app_en),
      .o_app_ack          (o_app_ack),
      .i_app_instr        (i_app_instr),
      .i_rdback_rden      (i_rdback_rden),
      .o_rdback_data      (o_rdback_data),
      .o_rdback_empty     (o_rdback_empty),
      .o_processing_iseq  (o_processing_iseq),
      .o_iq_full          (o_iq_full),
      .o_dfi_address      (o_dfi_address),
      .o_dfi_bank         (o_dfi_bank),
      .o_dfi_cs_n         (o_dfi_cs_n),
      .o_dfi_ras_n        (o_dfi_ras_n),
      .o_dfi_cas_n        (o_dfi_cas_n),
      .o_dfi_we_n         (o_dfi_we_n),
      .o_dfi_wrdata_en    (o_dfi_wrdata_en),
      .o_dfi_wrdata       (o_dfi_wrdata),
      .o_dfi_rddata_en    (o_dfi_rddata_en),
      .i_dfi_rddata       (i_dfi_rddata),
      .i_dfi_rddata_valid (i_dfi_rddata_valid)
   );

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   task automatic compare_val(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic start_seq(input int mode);
      seq_first[n_seq] = n_instr;
      seq_cmd_first[n_seq] = n_cmd;
      seq_mode[n_seq] = mode;
      pend_gap = -1;   // first command follows an unknown queue latency
   endtask

   task automatic add_ddr(input logic [3:0] ctl, input logic [2:0] bank,
                          input logic [15:0] addr, input bit loose);
      exp_cmd_t e;
      instr_tab[n_instr] = {softmc_instr_pkg::OP_DDR, ctl, 1'b0, bank, 4'h0, addr};
      e.gap = (loose || pend_gap < 0) ? 8'd0 : 8'(pend_gap);
      e.ctl = ctl;
      e.bank = bank;
      e.addr = addr;
      e.wr_en = (ctl == CTL_WR);
      e.rd_en = (ctl == CTL_RD);
      e.wrdata = {4{cur_pattern}};
      exp_tab[n_cmd] = e;
      n_cmd++;
      n_instr++;
      pend_gap = 1;
   endtask

   task automatic add_wait(input int n);
      instr_tab[n_instr] = {softmc_instr_pkg::OP_WAIT, 28'(n)};
      n_instr++;
      wait_sum += (n > 1) ? n : 1;
      if (pend_gap >= 0) begin
         pend_gap += (n > 1) ? n : 1;   // max(n,1) NOP cycles
      end
   endtask

   task automatic add_wrdata(input logic [15:0] p);
      instr_tab[n_instr] = {softmc_instr_pkg::OP_WRDATA, 12'h0, p};
      n_instr++;
      cur_pattern = p;
      if (pend_gap >= 0) begin
         pend_gap += 1;
      end
   endtask

   task automatic add_end();
      instr_tab[n_instr] = {softmc_instr_pkg::OP_END, 28'h0};
      n_instr++;
      seq_last[n_seq] = n_instr;
      seq_cmd_end[n_seq] = n_cmd;
      n_seq++;
   endtask

   task automatic build_table();
      start_seq(MODE_HOLD);
      add_ddr(CTL_MRS, 3'd0, 16'h0123, 1'b0);
      add_wait(3);
      add_ddr(CTL_ACT, 3'd2, 16'h1a5c, 1'b0);
      add_ddr(CTL_PRE, 3'd2, 16'h0400, 1'b0);
      add_wait(0);
      add_ddr(CTL_REF, 3'd0, 16'h0000, 1'b0);
      add_end();
      start_seq(MODE_PLAIN);
      add_ddr(CTL_ACT, 3'd1, 16'h0042, 1'b0);
      add_wait(5);
      add_wrdata(16'ha5c3);
      add_ddr(CTL_WR, 3'd1, 16'h0010, 1'b0);
      add_wait(1);
      add_wrdata(16'h5a3c);
      add_ddr(CTL_WR, 3'd1, 16'h0018, 1'b0);
      add_wait(12);
      add_ddr(CTL_PRE, 3'd1, 16'h0400, 1'b0);
      add_end();
      start_seq(MODE_READS);
      add_ddr(CTL_ACT, 3'd3, 16'h0777, 1'b0);
      for (int k = 0; k < N_READS; k++) begin
         // reads past the FIFO depth wait for credit
         add_ddr(CTL_RD, 3'd3, 16'h0100 + 16'(8 * k), k >= `SOFTMC_RB_DEPTH);
      end
      add_end();
      start_seq(MODE_OVERLAP);
      add_wait(60);
      add_end();
      start_seq(MODE_FILL);
      for (int k = 0; k < `SOFTMC_IQ_DEPTH - 3; k++) begin
         add_wait(0);
      end
      add_ddr(CTL_ACT, 3'd5, 16'h0abc, 1'b0);
      add_ddr(CTL_PRE, 3'd5, 16'h0000, 1'b0);
      add_end();
      limit_cycles = 3 * (n_instr + wait_sum) + 300;
   endtask

   // called at posedge+5, returns at posedge+5 after the transfer edge
   task automatic push_instr(input logic [31:0] w);
      logic done;
      done = 1'b0;
      i_app_en = 1'b1;
      i_app_instr = w;
      while (!done) begin
         @(negedge clk);
         done = o_app_ack;
         @(posedge clk);
         #5;
      end
      i_app_en = 1'b0;
   endtask

   task automatic pop_readback(input int n);
      logic [63:0] exp;
      for (int k = 0; k < n; k++) begin
         while (o_rdback_empty) begin
            @(posedge clk);
            #5;
         end
         if (exp_rdq.size() == 0) begin
            $display("readback word popped with no read data returned");
            err_cnt++;
         end else begin
            exp = exp_rdq.pop_front();
            compare_val("o_rdback_data", o_rdback_data, exp);
         end
         i_rdback_rden = 1'b1;
         @(posedge clk);
         #5;
         i_rdback_rden = 1'b0;
      end
   endtask

   task automatic wait_seq_done(input int s);
      while (cmd_idx < seq_cmd_end[s] || o_processing_iseq) begin
         @(posedge clk);
         #5;
      end
   endtask

   task automatic check_idle_outputs();
      compare_val("o_dfi_cs_n", o_dfi_cs_n, 1);
      compare_val("o_dfi_ras_n", o_dfi_ras_n, 1);
      compare_val("o_dfi_cas_n", o_dfi_cas_n, 1);
      compare_val("o_dfi_we_n", o_dfi_we_n, 1);
      compare_val("o_dfi_wrdata_en", o_dfi_wrdata_en, 0);
      compare_val("o_dfi_rddata_en", o_dfi_rddata_en, 0);
      compare_val("o_processing_iseq", o_processing_iseq, 0);
      compare_val("o_rdback_empty", o_rdback_empty, 1);
   endtask

   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (limit_cycles > 0 && cycle_cnt > limit_cycles) begin
         $display("timeout: run did not complete within %0d cycles", limit_cycles);
         $display("Finished with errors");
         $finish;
      end
   end

   // command monitor samples mid-cycle
   always @(negedge clk) begin : cmd_monitor
      exp_cmd_t e;
      int gap;
      if (i_rst_n && !o_dfi_cs_n) begin
         gap = cycle_cnt - last_cmd_cycle;
         if (cmd_idx >= n_cmd) begin
            $display("unexpected command at cycle %0d", cycle_cnt);
            err_cnt++;
         end else begin
            e = exp_tab[cmd_idx];
            compare_val("o_dfi_ras_n", o_dfi_ras_n, e.ctl[2]);
            compare_val("o_dfi_cas_n", o_dfi_cas_n, e.ctl[1]);
            compare_val("o_dfi_we_n", o_dfi_we_n, e.ctl[0]);
            compare_val("o_dfi_bank", o_dfi_bank, e.bank);
            compare_val("o_dfi_address", o_dfi_address, e.addr);
            compare_val("o_dfi_wrdata_en", o_dfi_wrdata_en, e.wr_en);
            compare_val("o_dfi_rddata_en", o_dfi_rddata_en, e.rd_en);
            if (e.gap != 0) begin
               compare_val("command gap", gap, e.gap);
            end
            if (e.wr_en) begin
               compare_val("o_dfi_wrdata", o_dfi_wrdata, e.wrdata);
            end
            cmd_idx++;
         end
         last_cmd_cycle = cycle_cnt;
      end else if (i_rst_n) begin
         compare_val("o_dfi_wrdata_en", o_dfi_wrdata_en, 0);   // no enable without a command
         compare_val("o_dfi_rddata_en", o_dfi_rddata_en, 0);
      end
   end

   // PHY read model returns data three cycles after rddata_en
   always @(negedge clk) begin
      rd_pipe_v <= {rd_pipe_v[1:0], (i_rst_n === 1'b1) & o_dfi_rddata_en};
      rd_pipe_a[0] <= o_dfi_address;
      rd_pipe_a[1] <= rd_pipe_a[0];
      rd_pipe_a[2] <= rd_pipe_a[1];
   end

   always @(posedge clk) begin : phy_return
      logic [63:0] word;
      #5;
      i_dfi_rddata_valid = 1'b0;
      if (rd_pipe_v[2]) begin
         rng = lcg_step(rng);
         word[63:32] = rng;
         rng = lcg_step(rng);
         word[31:0] = rng;
         word = word ^ {4{rd_pipe_a[2]}};
         i_dfi_rddata = word;
         i_dfi_rddata_valid = 1'b1;
         exp_rdq.push_back(word);
         rd_returned++;
      end
   end

   initial begin : main
      int s;
      int i;
      i_rst_n = 1'b0;
      i_app_en = 1'b0;
      i_app_instr = '0;
      i_rdback_rden = 1'b0;
      i_dfi_rddata = '0;
      i_dfi_rddata_valid = 1'b0;
      build_table();
      repeat (2) @(posedge clk);
      #5;
      i_rst_n = 1'b1;
      @(negedge clk);
      check_idle_outputs();
      @(posedge clk);
      #5;
      for (s = 0; s < n_seq; s++) begin
         if (seq_mode[s] == MODE_FILL) begin
            while (!o_processing_iseq) begin
               @(posedge clk);
               #5;
            end
            @(posedge clk);   // wait word of the running sequence is gone
            #5;
         end
         for (i = seq_first[s]; i < seq_last[s] - 1; i++) begin
            push_instr(instr_tab[i]);
         end
         if (seq_mode[s] == MODE_HOLD) begin
            repeat (5) @(posedge clk);
            #5;
            compare_val("o_processing_iseq", o_processing_iseq, 0);
            compare_val("commands before END", cmd_idx, seq_cmd_first[s]);
         end
         if (seq_mode[s] == MODE_FILL) begin
            compare_val("o_iq_full", o_iq_full, 1);
            compare_val("o_app_ack", o_app_ack, 0);
         end
         push_instr(instr_tab[seq_last[s] - 1]);
         if (seq_mode[s] == MODE_READS) begin
            while (rd_returned < `SOFTMC_RB_DEPTH) begin
               @(posedge clk);
               #5;
            end
            repeat (3) @(posedge clk);
            #5;
            compare_val("reads returned while FIFO full", rd_returned, `SOFTMC_RB_DEPTH);
            compare_val("o_processing_iseq", o_processing_iseq, 1);
            pop_readback(N_READS);
         end
         if (seq_mode[s] != MODE_OVERLAP) begin
            wait_seq_done(s);
         end
         if (seq_mode[s] == MODE_READS) begin
            compare_val("o_rdback_empty", o_rdback_empty, 1);
         end
      end
      repeat (2) @(posedge clk);
      if (cmd_idx != n_cmd) begin
         $display("only %0d of %0d expected commands were seen", cmd_idx, n_cmd);
         err_cnt++;
      end
      if (exp_rdq.size() != 0) begin
         $display("%0d read words were never popped", exp_rdq.size());
         err_cnt++;
      end
      $display("errors: %0d, commands checked: %0d, cycles: %0d", err_cnt, cmd_idx, cycle_cnt);
      if (err_cnt == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

// free running clock for the testbench
module tb_clk_gen #(
   parameter real PERIOD_NS = 100.0
) (
   output logic o_clk
);

   initial begin
      o_clk = 1'b0;
   end

   always begin
      #(PERIOD_NS / 2.0) o_clk = ~o_clk;
   end

endmodule

`default_nettype wire

/* softmc_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "softmc_defs.svh"

module softmc_top (
   input  logic                       i_clk,
   input  logic                       i_rst_n,
   // host instruction port
   input  logic                       i_app_en,
   output logic                       o_app_ack,
   input  logic [`SOFTMC_INSTR_W-1:0] i_app_instr,
   // host readback
   input  logic                       i_rdback_rden,
   output logic [`SOFTMC_BURST_W-1:0] o_rdback_data,
   output logic                       o_rdback_empty,
   // status
   output logic                       o_processing_iseq,
   output logic                       o_iq_full,
   // DFI command
   output logic [`SOFTMC_ROW_W-1:0]   o_dfi_address,
   output logic [`SOFTMC_BANK_W-1:0]  o_dfi_bank,
   output logic                       o_dfi_cs_n,
   output logic                       o_dfi_ras_n,
   output logic                       o_dfi_cas_n,
   output logic                       o_dfi_we_n,
   // DFI write and read
   output logic                       o_dfi_wrdata_en,
   output logic [`SOFTMC_BURST_W-1:0] o_dfi_wrdata,
   output logic                       o_dfi_rddata_en,
   input  logic [`SOFTMC_BURST_W-1:0] i_dfi_rddata,
   input  logic                       i_dfi_rddata_valid
);

   instr_if iq_if ();

   dfi_pkg::dfi_cmd_t dfi_cmd;
   logic              rd_issue;
   logic              rd_credit;

   instr_queue u_instr_queue (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_app_en    (i_app_en),
      .i_app_instr (i_app_instr),
      .o_app_ack   (o_app_ack),
      .o_iq_full   (o_iq_full),
      .iq          (iq_if.queue)
   );

   iseq_sequencer u_iseq_sequencer (
      .i_clk             (i_clk),
      .i_rst_n           (i_rst_n),
      .iq                (iq_if.seq),
      .i_rd_credit       (rd_credit),
      .o_rd_issue        (rd_issue),
      .o_processing_iseq (o_processing_iseq),
      .o_dfi_cmd         (dfi_cmd),
      .o_dfi_wrdata_en   (o_dfi_wrdata_en),
      .o_dfi_wrdata      (o_dfi_wrdata),
      .o_dfi_rddata_en   (o_dfi_rddata_en)
   );

   rdback_fifo u_rdback_fifo (
      .i_clk          (i_clk),
      .i_rst_n        (i_rst_n),
      .i_rd_issue     (rd_issue),
      .o_rd_credit    (rd_credit),
      .i_rddata_valid (i_dfi_rddata_valid),
      .i_rddata       (i_dfi_rddata),
      .i_rden         (i_rdback_rden),
      .o_rdata        (o_rdback_data),
      .o_empty        (o_rdback_empty)
   );

   // command slot onto the pins
   assign o_dfi_cs_n    = dfi_cmd.cs_n;
   assign o_dfi_ras_n   = dfi_cmd.ras_n;
   assign o_dfi_cas_n   = dfi_cmd.cas_n;
   assign o_dfi_we_n    = dfi_cmd.we_n;
   assign o_dfi_bank    = dfi_cmd.bank;
   assign o_dfi_address = dfi_cmd.address;

endmodule

`default_nettype wire

/* rdback_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "softmc_defs.svh"

module rdback_fifo (
   input  logic                       i_clk,
   input  logic                       i_rst_n,
   input  logic                       i_rd_issue,
   output logic                       o_rd_credit,
   input  logic                       i_rddata_valid,
   input  logic [`SOFTMC_BURST_W-1:0] i_rddata,
   input  logic                       i_rden,
   output logic [`SOFTMC_BURST_W-1:0] o_rdata,
   output logic                       o_empty
);

   localparam int PTR_W = $clog2(`SOFTMC_RB_DEPTH);

   logic [`SOFTMC_BURST_W-1:0] mem [`SOFTMC_RB_DEPTH];

   logic [PTR_W-1:0]           wr_ptr_q;
   logic [PTR_W-1:0]           rd_ptr_q;
   logic [PTR_W:0]             count_q;
   logic [PTR_W:0]             resv_q;      // reads issued whose data is not yet stored
   logic [PTR_W+1:0]           occupancy;
   logic                       cap_valid_q;
   logic [`SOFTMC_BURST_W-1:0] cap_data_q;
   logic                       pop;

   assign o_empty     = (count_q == '0);
   assign o_rdata     = mem[rd_ptr_q];
   assign pop         = i_rden & ~o_empty;
   assign occupancy   = count_q + resv_q;
   assign o_rd_credit = (occupancy < `SOFTMC_RB_DEPTH);

   // PHY data lands one cycle after its valid
   always_ff @(posedge i_clk) begin
      cap_data_q <= i_rddata;
      if (cap_valid_q) begin
         mem[wr_ptr_q] <= cap_data_q;
      end
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         cap_valid_q <= 1'b0;
         wr_ptr_q    <= '0;
         rd_ptr_q    <= '0;
         count_q     <= '0;
         resv_q      <= '0;
      end else begin
         cap_valid_q <= i_rddata_valid;
         if (cap_valid_q) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end

         if (cap_valid_q && !pop) begin
            count_q <= count_q + 1'b1;
         end else if (pop && !cap_valid_q) begin
            count_q <= count_q - 1'b1;
         end

         // slot moves from reserved to stored on the write
         if (i_rd_issue && !cap_valid_q) begin
            resv_q <= resv_q + 1'b1;
         end else if (cap_valid_q && !i_rd_issue) begin
            resv_q <= resv_q - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* iseq_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "softmc_defs.svh"

module iseq_sequencer (
   input  logic                       i_clk,
   input  logic                       i_rst_n,
   instr_if.seq                       iq,
   input  logic                       i_rd_credit,
   output logic                       o_rd_issue,
   output logic                       o_processing_iseq,
   output dfi_pkg::dfi_cmd_t          o_dfi_cmd,
   output logic                       o_dfi_wrdata_en,
   output logic [`SOFTMC_BURST_W-1:0] o_dfi_wrdata,
   output logic                       o_dfi_rddata_en
);

   localparam dfi_pkg::dfi_cmd_t NOP_CMD = '{
      cs_n:    1'b1,
      ras_n:   1'b1,
      cas_n:   1'b1,
      we_n:    1'b1,
      bank:    '0,
      address: '0
   };

   softmc_instr_pkg::seq_state_e state_q;

   dfi_pkg::dfi_cmd_t         cmd_q;
   dfi_pkg::dfi_cmd_t         hold_cmd_q;    // read waiting for credit
   dfi_pkg::dfi_cmd_t         dec_cmd;
   dfi_pkg::dram_cmd_e        dec_class;
   logic                      dec_rd;
   logic                      dec_wr;
   logic [`SOFTMC_WAIT_W-1:0] dec_wait;
   logic                      fetch;
   logic                      is_ddr;
   logic                      rd_stall;
   logic                      wrdata_en_q;
   logic                      rddata_en_q;
   logic [`SOFTMC_WAIT_W-1:0] wait_cnt_q;
   logic [`SOFTMC_DQ_W-1:0]   pattern_q;

   // OP_DDR field split of the queue head
   always_comb begin
      dec_cmd.cs_n    = iq.instr.body[27];
      dec_cmd.ras_n   = iq.instr.body[26];
      dec_cmd.cas_n   = iq.instr.body[25];
      dec_cmd.we_n    = iq.instr.body[24];
      dec_cmd.bank    = iq.instr.body[20 +: `SOFTMC_BANK_W];
      dec_cmd.address = iq.instr.body[0 +: `SOFTMC_ROW_W];
   end

   assign dec_class = dfi_pkg::dram_cmd_e'({dec_cmd.ras_n, dec_cmd.cas_n, dec_cmd.we_n});
   assign dec_rd    = ~dec_cmd.cs_n & (dec_class == dfi_pkg::RD);
   assign dec_wr    = ~dec_cmd.cs_n & (dec_class == dfi_pkg::WR);
   assign dec_wait  = iq.instr.body[`SOFTMC_WAIT_W-1:0];

   assign fetch    = (state_q == softmc_instr_pkg::FETCH) & iq.valid;
   assign is_ddr   = fetch & (iq.instr.op == softmc_instr_pkg::OP_DDR);
   assign rd_stall = is_ddr & dec_rd & ~i_rd_credit;

   assign iq.pop = fetch;   // every fetched word is consumed

   // FIFO slot is reserved in the same cycle as the read decision
   assign o_rd_issue = (is_ddr & dec_rd & i_rd_credit) |
                       ((state_q == softmc_instr_pkg::EXEC) & i_rd_credit);

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state_q     <= softmc_instr_pkg::IDLE;
         cmd_q       <= NOP_CMD;
         wrdata_en_q <= 1'b0;
         rddata_en_q <= 1'b0;
         wait_cnt_q  <= '0;
         pattern_q   <= '0;
      end else begin
         cmd_q       <= NOP_CMD;   // deselect unless a command goes out
         wrdata_en_q <= 1'b0;
         rddata_en_q <= 1'b0;
         case (state_q)
            softmc_instr_pkg::IDLE: begin
               if (iq.seq_ready) begin
                  state_q <= softmc_instr_pkg::FETCH;
               end
            end
            softmc_instr_pkg::FETCH: begin
               if (iq.valid) begin
                  case (iq.instr.op)
                     softmc_instr_pkg::OP_DDR: begin
                        if (rd_stall) begin
                           state_q <= softmc_instr_pkg::EXEC;
                        end else begin
                           cmd_q       <= dec_cmd;
                           wrdata_en_q <= dec_wr;
                           rddata_en_q <= dec_rd;
                        end
                     end
                     softmc_instr_pkg::OP_WAIT: begin
                        // this cycle is the first NOP
                        if (dec_wait > 1) begin
                           wait_cnt_q <= dec_wait - 1'b1;
                           state_q    <= softmc_instr_pkg::WAIT;
                        end
                     end
                     softmc_instr_pkg::OP_WRDATA: begin
                        pattern_q <= iq.instr.body[`SOFTMC_DQ_W-1:0];
                     end
                     softmc_instr_pkg::OP_END: begin
                        state_q <= softmc_instr_pkg::IDLE;
                     end
                     default: begin
                        state_q <= softmc_instr_pkg::FETCH;   // unknown op costs a NOP
                     end
                  endcase
               end
            end
            softmc_instr_pkg::EXEC: begin
               if (i_rd_credit) begin
                  cmd_q       <= hold_cmd_q;
                  rddata_en_q <= 1'b1;
                  state_q     <= softmc_instr_pkg::FETCH;
               end
            end
            softmc_instr_pkg::WAIT: begin
               if (wait_cnt_q == 1) begin
                  state_q <= softmc_instr_pkg::FETCH;
               end else begin
                  wait_cnt_q <= wait_cnt_q - 1'b1;
               end
            end
            default: state_q <= softmc_instr_pkg::IDLE;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (rd_stall) begin
         hold_cmd_q <= dec_cmd;
      end
   end

   assign o_processing_iseq = (state_q != softmc_instr_pkg::IDLE);
   assign o_dfi_cmd         = cmd_q;
   assign o_dfi_wrdata_en   = wrdata_en_q;
   assign o_dfi_rddata_en   = rddata_en_q;
   assign o_dfi_wrdata      = {(`SOFTMC_BURST_W / `SOFTMC_DQ_W){pattern_q}};   // pattern per beat

endmodule

`default_nettype wire

/* instr_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "softmc_defs.svh"

module instr_queue (
   input  logic                     i_clk,
   input  logic                     i_rst_n,
   input  logic                     i_app_en,
   input  softmc_instr_pkg::instr_t i_app_instr,
   output logic                     o_app_ack,
   output logic                     o_iq_full,
   instr_if.queue                   iq
);

   localparam int PTR_W = $clog2(`SOFTMC_IQ_DEPTH);

   softmc_instr_pkg::instr_t mem [`SOFTMC_IQ_DEPTH];

   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [PTR_W:0]   count_q;
   logic [PTR_W:0]   end_cnt_q;    // END words currently stored
   logic             full;
   logic             push;
   logic             pop;
   logic             push_end;
   logic             pop_end;

   assign full      = (count_q == `SOFTMC_IQ_DEPTH);
   assign o_app_ack = ~full;
   assign o_iq_full = full;

   assign push     = i_app_en & ~full;
   assign pop      = iq.pop & iq.valid;
   assign push_end = push & (i_app_instr.op == softmc_instr_pkg::OP_END);
   assign pop_end  = pop & (iq.instr.op == softmc_instr_pkg::OP_END);

   // head is read straight out of the array
   assign iq.valid     = (count_q != '0);
   assign iq.instr     = mem[rd_ptr_q];
   assign iq.seq_ready = (end_cnt_q != '0);   // never start on half a sequence

   always_ff @(posedge i_clk) begin
      if (push) begin
         mem[wr_ptr_q] <= i_app_instr;
      end
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         wr_ptr_q  <= '0;
         rd_ptr_q  <= '0;
         count_q   <= '0;
         end_cnt_q <= '0;
      end else begin
         // pointers wrap on their own
         if (push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end

         if (push && !pop) begin
            count_q <= count_q + 1'b1;
         end else if (pop && !push) begin
            count_q <= count_q - 1'b1;
         end

         if (push_end && !pop_end) begin
            end_cnt_q <= end_cnt_q + 1'b1;
         end else if (pop_end && !push_end) begin
            end_cnt_q <= end_cnt_q - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* instr_if.sv */
`timescale 1ns/1ps
`default_nettype none

// queue head presented to the sequencer
interface instr_if;

   logic                     valid;      // head holds an instruction
   softmc_instr_pkg::instr_t instr;
   logic                     seq_ready;  // at least one END stored
   logic                     pop;

   modport queue (
      output valid,
      output instr,
      output seq_ready,
      input  pop
   );

   modport seq (
      input  valid,
      input  instr,
      input  seq_ready,
      output pop
   );

endinterface

`default_nettype wire

/* dfi_pkg.sv */
`default_nettype none

`include "softmc_defs.svh"

package dfi_pkg;

   // command class by {ras_n, cas_n, we_n}
   typedef enum logic [2:0] {
      MRS = 3'b000,
      REF = 3'b001,
      PRE = 3'b010,
      ACT = 3'b011,
      WR  = 3'b100,
      RD  = 3'b101,
      NOP = 3'b111
   } dram_cmd_e;

   // one command slot on the DFI
   typedef struct packed {
      logic                      cs_n;
      logic                      ras_n;
      logic                      cas_n;
      logic                      we_n;
      logic [`SOFTMC_BANK_W-1:0] bank;
      logic [`SOFTMC_ROW_W-1:0]  address;
   } dfi_cmd_t;

endpackage

`default_nettype wire

/* softmc_instr_pkg.sv */
`default_nettype none

`include "softmc_defs.svh"

package softmc_instr_pkg;

   // opcode sits in the top nibble of the instruction
   typedef enum logic [3:0] {
      OP_DDR    = 4'h1,   // raw cs/ras/cas/we, bank and address
      OP_WAIT   = 4'h2,   // NOP for a number of cycles
      OP_WRDATA = 4'h3,   // new write pattern
      OP_END    = 4'h4    // last word of a sequence
   } instr_op_e;

   // OP_DDR body
   //   [27:24] cs_n ras_n cas_n we_n
   //   [22:20] bank
   //   [15:0]  address
   // OP_WAIT body [27:0] is the cycle count
   // OP_WRDATA body [15:0] is the pattern
   typedef struct packed {
      instr_op_e                   op;
      logic [`SOFTMC_INSTR_W-5:0]  body;
   } instr_t;

   // sequencer FSM
   typedef enum logic [1:0] {
      IDLE,    // no complete sequence queued
      FETCH,   // one instruction per cycle
      EXEC,    // read held back until credit returns
      WAIT     // counting NOP cycles
   } seq_state_e;

endpackage

`default_nettype wire

/* softmc_defs.svh */
`ifndef SOFTMC_DEFS_SVH
`define SOFTMC_DEFS_SVH

// host instruction word
`define SOFTMC_INSTR_W 32

// DRAM command bus
`define SOFTMC_ROW_W   16
`define SOFTMC_BANK_W  3

// data path widths
`define SOFTMC_DQ_W    16
`define SOFTMC_BURST_W (4 * `SOFTMC_DQ_W)   // four beats per burst

// queue depths, both powers of two
`define SOFTMC_IQ_DEPTH 16
`define SOFTMC_RB_DEPTH 8

// count field of OP_WAIT
`define SOFTMC_WAIT_W  28

`endif
